// ==== rtl/switch_pkg.sv ====
// Single sys_clk domain; queue words carry bit 8 set on frame data and clear on the closing word
package switch_pkg;

  localparam int NPORT = 4;

  typedef logic [1:0] port_idx_t;
  typedef logic [7:0] byte_t;
  typedef logic [8:0] phy_word_t;
  typedef logic [47:0] mac_t;

  // Destination MAC only, first byte on the wire is the top byte
  localparam int MAC_BYTES = 6;

  localparam int FLOW_ENTRIES = 4;
  typedef logic [1:0] flow_idx_t;

  localparam int MAX_FRAME_BYTES = 64;
  localparam int QUEUE_DEPTH = 128;
  typedef logic [7:0] q_count_t;

  localparam int IFG_CYCLES = 8;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    GAP
  } mix_state_t;

  // Nearest requester after last, wrapping; last itself ranks lowest
  function automatic port_idx_t rr_next(logic [NPORT-1:0] reqs, port_idx_t last);
    port_idx_t cand;
    port_idx_t win;
    win = last;
    for (int k = NPORT; k >= 1; k--) begin
      cand = last + port_idx_t'(k);
      if (reqs[cand]) begin
        win = cand;
      end
    end
    return win;
  endfunction

endpackage

// ==== rtl/byte_fifo.sv ====
// FWFT queue of QUEUE_DEPTH words; writes while full and reads while empty are ignored
`timescale 1ns/1ps

module byte_fifo import switch_pkg::*; (
  input  logic      sys_clk,
  input  logic      rst_n,
  input  phy_word_t din,
  input  logic      wr_en,
  output logic      full,
  output phy_word_t dout,
  output logic      empty,
  input  logic      rd_en,
  output q_count_t  count
);

  localparam int AW = $clog2(QUEUE_DEPTH);

  phy_word_t     mem [QUEUE_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_wr;
  logic          do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign full  = (count == q_count_t'(QUEUE_DEPTH));
  assign empty = (count == '0);
  // Head word is visible without a read
  assign dout  = mem[rd_ptr];

  always_ff @(posedge sys_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/gmii_rx_gate.sv ====
// Frames are admitted whole or not at all; bytes past MAX_FRAME_BYTES are cut but the frame still closes
`timescale 1ns/1ps

module gmii_rx_gate import switch_pkg::*; (
  input  logic      sys_clk,
  input  logic      rst_n,
  input  logic      rx_dv,
  input  byte_t     rxd,
  input  q_count_t  q_count,
  output phy_word_t q_din,
  output logic      q_wr_en
);

  // Room for a longest frame plus its closing word
  localparam q_count_t ADMIT_LIMIT = q_count_t'(QUEUE_DEPTH - MAX_FRAME_BYTES - 1);
  localparam logic [6:0] MAX_CNT = 7'(MAX_FRAME_BYTES);

  logic       in_frame;
  logic       admitted;
  logic [6:0] byte_cnt;
  logic       admit_ok;

  // A word still in flight is not yet in q_count
  assign admit_ok = (q_count + q_count_t'(q_wr_en)) <= ADMIT_LIMIT;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      in_frame <= 1'b0;
      admitted <= 1'b0;
      byte_cnt <= '0;
      q_wr_en  <= 1'b0;
    end else begin
      q_wr_en <= 1'b0;
      if (rx_dv) begin
        if (!in_frame) begin
          in_frame <= 1'b1;
          admitted <= admit_ok;
          byte_cnt <= 7'd1;
          q_wr_en  <= admit_ok;
        end else if (admitted && byte_cnt < MAX_CNT) begin
          byte_cnt <= byte_cnt + 1'b1;
          q_wr_en  <= 1'b1;
        end
      end else if (in_frame) begin
        in_frame <= 1'b0;
        q_wr_en  <= admitted;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    q_din <= rx_dv ? {1'b1, rxd} : {1'b0, 8'h00};
  end

endmodule

// ==== rtl/flow_table.sv ====
// One lookup in flight at a time; the lowest valid matching entry wins, all entries invalid after reset
`timescale 1ns/1ps

module flow_table import switch_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  logic                  tbl_wr_en,
  input  flow_idx_t             tbl_wr_idx,
  input  mac_t                  tbl_wr_mac,
  input  port_idx_t             tbl_wr_port,
  input  logic [NPORT-1:0]      lookup_req,
  input  mac_t [NPORT-1:0]      lookup_mac,
  output logic [NPORT-1:0]      lookup_ack,
  output logic [NPORT-1:0]      lookup_hit,
  output port_idx_t [NPORT-1:0] lookup_port
);

  typedef enum logic [1:0] {
    T_IDLE,
    T_LOOK,
    T_HOLD
  } tbl_state_t;

  mac_t                    ent_mac  [FLOW_ENTRIES];
  port_idx_t               ent_port [FLOW_ENTRIES];
  logic [FLOW_ENTRIES-1:0] ent_valid;

  tbl_state_t       state;
  port_idx_t        grant;
  logic [NPORT-1:0] pending;
  logic             match_hit;
  port_idx_t        match_port;

  assign pending = lookup_req & ~lookup_ack;

  // --------------------------------------------------
  // Table storage
  // --------------------------------------------------
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_valid <= '0;
    end else if (tbl_wr_en) begin
      ent_valid[tbl_wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (tbl_wr_en) begin
      ent_mac[tbl_wr_idx]  <= tbl_wr_mac;
      ent_port[tbl_wr_idx] <= tbl_wr_port;
    end
  end

  // Scan downwards so the lowest index ends up winning
  always_comb begin
    match_hit  = 1'b0;
    match_port = '0;
    for (int e = FLOW_ENTRIES - 1; e >= 0; e--) begin
      if (ent_valid[e] && ent_mac[e] == lookup_mac[grant]) begin
        match_hit  = 1'b1;
        match_port = ent_port[e];
      end
    end
  end

  // --------------------------------------------------
  // Arbiter and four-phase return
  // --------------------------------------------------
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= T_IDLE;
      grant      <= port_idx_t'(NPORT - 1);
      lookup_ack <= '0;
    end else begin
      case (state)
        T_IDLE: begin
          if (|pending) begin
            grant <= rr_next(pending, grant);
            state <= T_LOOK;
          end
        end
        T_LOOK: begin
          lookup_ack[grant] <= 1'b1;
          state             <= T_HOLD;
        end
        T_HOLD: begin
          if (!lookup_req[grant]) begin
            lookup_ack[grant] <= 1'b0;
            if (|pending) begin
              grant <= rr_next(pending, grant);
              state <= T_LOOK;
            end else begin
              state <= T_IDLE;
            end
          end
        end
        default: state <= T_IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == T_LOOK) begin
      lookup_hit[grant]  <= match_hit;
      lookup_port[grant] <= match_port;
    end
  end

endmodule

// ==== rtl/forwarder.sv ====
// Frames shorter than MAC_BYTES and lookup misses are popped and discarded without any write
`timescale 1ns/1ps

module forwarder import switch_pkg::*; (
  input  logic             sys_clk,
  input  logic             rst_n,
  input  phy_word_t        rx_dout,
  input  logic             rx_empty,
  output logic             rx_rd_en,
  output logic             lookup_req,
  output mac_t             lookup_mac,
  input  logic             lookup_ack,
  input  logic             lookup_hit,
  input  port_idx_t        lookup_port,
  output phy_word_t        tx_din,
  output logic [NPORT-1:0] tx_wr_en,
  input  logic [NPORT-1:0] tx_full
);

  typedef enum logic [2:0] {
    F_HDR,
    F_LOOK,
    F_REPLAY,
    F_BODY,
    F_DROP
  } fwd_state_t;

  localparam logic [2:0] LAST_HDR = 3'(MAC_BYTES - 1);
  localparam int MAC_MSB = $bits(mac_t) - 1;

  fwd_state_t state;
  logic [2:0] hdr_cnt;
  port_idx_t  out_port;
  logic       rx_data;
  logic       can_write;
  logic       wr_go;

  assign rx_data   = rx_dout[8];
  assign can_write = !tx_full[out_port];

  always_comb begin
    rx_rd_en = 1'b0;
    wr_go    = 1'b0;
    tx_din   = rx_dout;
    case (state)
      F_HDR, F_DROP: begin
        rx_rd_en = !rx_empty;
      end
      F_REPLAY: begin
        wr_go  = can_write;
        tx_din = {1'b1, lookup_mac[MAC_MSB -: 8]};
      end
      F_BODY: begin
        wr_go    = can_write && !rx_empty;
        rx_rd_en = wr_go;
      end
      default: ;
    endcase
  end

  always_comb begin
    tx_wr_en           = '0;
    tx_wr_en[out_port] = wr_go;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= F_HDR;
      hdr_cnt    <= '0;
      out_port   <= '0;
      lookup_req <= 1'b0;
    end else begin
      case (state)
        F_HDR: begin
          if (rx_rd_en) begin
            if (!rx_data) begin
              // Short frame ends here
              hdr_cnt <= '0;
            end else if (hdr_cnt == LAST_HDR) begin
              hdr_cnt    <= '0;
              lookup_req <= !lookup_ack;
              state      <= F_LOOK;
            end else begin
              hdr_cnt <= hdr_cnt + 1'b1;
            end
          end
        end
        F_LOOK: begin
          if (lookup_req && lookup_ack) begin
            lookup_req <= 1'b0;
            out_port   <= lookup_port;
            state      <= lookup_hit ? F_REPLAY : F_DROP;
          end else if (!lookup_req && !lookup_ack) begin
            lookup_req <= 1'b1;
          end
        end
        F_REPLAY: begin
          if (wr_go) begin
            if (hdr_cnt == LAST_HDR) begin
              hdr_cnt <= '0;
              state   <= F_BODY;
            end else begin
              hdr_cnt <= hdr_cnt + 1'b1;
            end
          end
        end
        F_BODY, F_DROP: begin
          if (rx_rd_en && !rx_data) begin
            state <= F_HDR;
          end
        end
        default: state <= F_HDR;
      endcase
    end
  end

  // Header shifts in on capture and back out on replay
  always_ff @(posedge sys_clk) begin
    if (state == F_HDR && rx_rd_en) begin
      lookup_mac <= {lookup_mac[MAC_MSB-8:0], rx_dout[7:0]};
    end else if (state == F_REPLAY && wr_go) begin
      lookup_mac <= lookup_mac << 8;
    end
  end

endmodule

// ==== rtl/tx_mixer.sv ====
// Assumes a started frame keeps its queue fed until the closing word, else tx_en drops mid-frame
`timescale 1ns/1ps

module tx_mixer import switch_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  phy_word_t [NPORT-1:0] q_dout,
  input  logic [NPORT-1:0]      q_empty,
  output logic [NPORT-1:0]      q_rd_en,
  output logic                  tx_en,
  output byte_t                 txd
);

  // IDLE and the first SEND cycle also count as gap
  localparam logic [3:0] GAP_LOAD = 4'(IFG_CYCLES - 3);

  mix_state_t state;
  port_idx_t  sel;
  logic [3:0] gap_cnt;
  phy_word_t  word;

  assign word = q_dout[sel];

  always_comb begin
    q_rd_en = '0;
    if (state == SEND) begin
      q_rd_en[sel] = !q_empty[sel];
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      sel     <= port_idx_t'(NPORT - 1);
      gap_cnt <= '0;
      tx_en   <= 1'b0;
      txd     <= '0;
    end else begin
      tx_en <= 1'b0;
      case (state)
        IDLE: begin
          if (!(&q_empty)) begin
            sel   <= rr_next(~q_empty, sel);
            state <= SEND;
          end
        end
        SEND: begin
          if (q_rd_en[sel]) begin
            tx_en <= word[8];
            txd   <= word[7:0];
            if (!word[8]) begin
              gap_cnt <= GAP_LOAD;
              state   <= GAP;
            end
          end
        end
        GAP: begin
          if (gap_cnt == '0) begin
            state <= IDLE;
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/switch_top.sv ====
// Four ports in one clock domain; back-pressure is internal, a full receive queue drops whole frames
`timescale 1ns/1ps

module switch_top import switch_pkg::*; (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic [NPORT-1:0]  gmii_rx_dv,
  input  byte_t [NPORT-1:0] gmii_rxd,
  output logic [NPORT-1:0]  gmii_tx_en,
  output byte_t [NPORT-1:0] gmii_txd,
  input  logic              tbl_wr_en,
  input  flow_idx_t         tbl_wr_idx,
  input  mac_t              tbl_wr_mac,
  input  port_idx_t         tbl_wr_port
);

  phy_word_t rx_din   [NPORT];
  logic      rx_wr_en [NPORT];
  q_count_t  rx_count [NPORT];
  phy_word_t rx_dout  [NPORT];
  logic      rx_empty [NPORT];
  logic      rx_rd_en [NPORT];

  logic [NPORT-1:0]      lookup_req;
  mac_t [NPORT-1:0]      lookup_mac;
  logic [NPORT-1:0]      lookup_ack;
  logic [NPORT-1:0]      lookup_hit;
  port_idx_t [NPORT-1:0] lookup_port;

  // Forwarder side indexed [in][out], mixer side [out][in]
  phy_word_t             fwd_din   [NPORT];
  logic [NPORT-1:0]      fwd_wr_en [NPORT];
  logic [NPORT-1:0]      fwd_full  [NPORT];
  phy_word_t [NPORT-1:0] mix_dout  [NPORT];
  logic [NPORT-1:0]      mix_empty [NPORT];
  logic [NPORT-1:0]      mix_rd_en [NPORT];

  // --------------------------------------------------
  // Receive path per port
  // --------------------------------------------------
  for (genvar i = 0; i < NPORT; i++) begin : g_rx
    gmii_rx_gate u_gate (
      .sys_clk (sys_clk),
      .rst_n   (rst_n),
      .rx_dv   (gmii_rx_dv[i]),
      .rxd     (gmii_rxd[i]),
      .q_count (rx_count[i]),
      .q_din   (rx_din[i]),
      .q_wr_en (rx_wr_en[i])
    );

    byte_fifo u_rxq (
      .sys_clk (sys_clk),
      .rst_n   (rst_n),
      .din     (rx_din[i]),
      .wr_en   (rx_wr_en[i]),
      .full    (),
      .dout    (rx_dout[i]),
      .empty   (rx_empty[i]),
      .rd_en   (rx_rd_en[i]),
      .count   (rx_count[i])
    );

    forwarder u_fwd (
      .sys_clk     (sys_clk),
      .rst_n       (rst_n),
      .rx_dout     (rx_dout[i]),
      .rx_empty    (rx_empty[i]),
      .rx_rd_en    (rx_rd_en[i]),
      .lookup_req  (lookup_req[i]),
      .lookup_mac  (lookup_mac[i]),
      .lookup_ack  (lookup_ack[i]),
      .lookup_hit  (lookup_hit[i]),
      .lookup_port (lookup_port[i]),
      .tx_din      (fwd_din[i]),
      .tx_wr_en    (fwd_wr_en[i]),
      .tx_full     (fwd_full[i])
    );
  end

  flow_table u_flow (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .tbl_wr_en   (tbl_wr_en),
    .tbl_wr_idx  (tbl_wr_idx),
    .tbl_wr_mac  (tbl_wr_mac),
    .tbl_wr_port (tbl_wr_port),
    .lookup_req  (lookup_req),
    .lookup_mac  (lookup_mac),
    .lookup_ack  (lookup_ack),
    .lookup_hit  (lookup_hit),
    .lookup_port (lookup_port)
  );

  // --------------------------------------------------
  // Crossbar queues and transmit mixers
  // --------------------------------------------------
  for (genvar i = 0; i < NPORT; i++) begin : g_xin
    for (genvar o = 0; o < NPORT; o++) begin : g_xout
      byte_fifo u_xq (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .din     (fwd_din[i]),
        .wr_en   (fwd_wr_en[i][o]),
        .full    (fwd_full[i][o]),
        .dout    (mix_dout[o][i]),
        .empty   (mix_empty[o][i]),
        .rd_en   (mix_rd_en[o][i]),
        .count   ()
      );
    end
  end

  for (genvar o = 0; o < NPORT; o++) begin : g_tx
    tx_mixer u_mix (
      .sys_clk (sys_clk),
      .rst_n   (rst_n),
      .q_dout  (mix_dout[o]),
      .q_empty (mix_empty[o]),
      .q_rd_en (mix_rd_en[o]),
      .tx_en   (gmii_tx_en[o]),
      .txd     (gmii_txd[o])
    );
  end

endmodule

// ==== verif/tb_switch.sv ====
// Random test keeps idle spacing wide enough that no receive queue ever drops a frame
`timescale 1ns/1ps

module tb_switch import switch_pkg::*; ();

  localparam int MAX_FRAMES    = 200;
  localparam int MAX_IDLE      = 48;
  localparam int SETTLE_CYCLES = 300;
  localparam int DRAIN_LIMIT   = 20000;
  localparam int WD_CYCLES     = 2 * NPORT * MAX_FRAMES *
                                 (MAX_FRAME_BYTES + 1 + IFG_CYCLES + MAX_IDLE) + 6 * SETTLE_CYCLES;

  logic              sys_clk = 1'b0;
  logic              rst_n;
  logic [NPORT-1:0]  gmii_rx_dv;
  byte_t [NPORT-1:0] gmii_rxd;
  logic [NPORT-1:0]  gmii_tx_en;
  byte_t [NPORT-1:0] gmii_txd;
  logic              tbl_wr_en;
  flow_idx_t         tbl_wr_idx;
  mac_t              tbl_wr_mac;
  port_idx_t         tbl_wr_port;

  // Table model
  logic      model_valid [FLOW_ENTRIES];
  mac_t      model_mac   [FLOW_ENTRIES];
  port_idx_t model_port  [FLOW_ENTRIES];

  // Frame store, stimulus per input and expected ids per [out][src]
  byte_t     frame_mem [MAX_FRAMES][MAX_FRAME_BYTES];
  int        frame_len [MAX_FRAMES];
  phy_word_t stim_q    [NPORT][$];
  int        exp_q     [NPORT][NPORT][$];

  byte_t got_buf  [NPORT][MAX_FRAME_BYTES];
  int    got_len  [NPORT];
  int    idle_cnt [NPORT];
  bit    in_frame [NPORT];
  bit    seen     [NPORT];

  integer seed;
  int     n_frames;
  int     queued_cnt;
  int     done_cnt;
  int     err_main;
  int     err_mon;
  int     errs_before;
  int     n_tests;
  mac_t   mac;
  int     len;

  switch_top dut (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .gmii_rx_dv  (gmii_rx_dv),
    .gmii_rxd    (gmii_rxd),
    .gmii_tx_en  (gmii_tx_en),
    .gmii_txd    (gmii_txd),
    .tbl_wr_en   (tbl_wr_en),
    .tbl_wr_idx  (tbl_wr_idx),
    .tbl_wr_mac  (tbl_wr_mac),
    .tbl_wr_port (tbl_wr_port)
  );

  always #4 sys_clk = ~sys_clk;

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Output port for a frame, or -1 when the switch must drop it
  function automatic int expected_port(input mac_t key, input int bytes);
    int res;
    res = -1;
    if (bytes >= MAC_BYTES) begin
      for (int e = 0; e < FLOW_ENTRIES; e++) begin
        if (res < 0 && model_valid[e] && model_mac[e] == key) begin
          res = int'(model_port[e]);
        end
      end
    end
    return res;
  endfunction

  function automatic int first_diff(input int id, input int o);
    int n;
    n = (got_len[o] < frame_len[id]) ? got_len[o] : frame_len[id];
    for (int k = 0; k < n; k++) begin
      if (got_buf[o][k] != frame_mem[id][k]) begin
        return k;
      end
    end
    if (got_len[o] != frame_len[id]) begin
      return n;
    end
    return -1;
  endfunction

  task automatic write_entry(input int idx, input mac_t key, input int port);
    @(negedge sys_clk);
    tbl_wr_en   = 1'b1;
    tbl_wr_idx  = flow_idx_t'(idx);
    tbl_wr_mac  = key;
    tbl_wr_port = port_idx_t'(port);
    @(negedge sys_clk);
    tbl_wr_en          = 1'b0;
    model_valid[idx]   = 1'b1;
    model_mac[idx]     = key;
    model_port[idx]    = port_idx_t'(port);
  endtask

  // MAC goes out first, top byte first; payload is random
  task automatic queue_frame(input int p, input mac_t key, input int bytes, input int idle);
    int id;
    int dest;
    id = n_frames;
    n_frames++;
    frame_len[id] = bytes;
    for (int k = 0; k < bytes; k++) begin
      if (k < MAC_BYTES) begin
        frame_mem[id][k] = key[47 - 8*k -: 8];
      end else begin
        frame_mem[id][k] = byte_t'($random(seed));
      end
      stim_q[p].push_back({1'b1, frame_mem[id][k]});
    end
    repeat (idle) stim_q[p].push_back('0);
    dest = expected_port(key, bytes);
    if (dest >= 0) begin
      exp_q[dest][p].push_back(id);
      queued_cnt++;
    end
  endtask

  task automatic play_stimulus();
    bit        busy;
    phy_word_t w;
    busy = 1'b1;
    while (busy) begin
      @(negedge sys_clk);
      busy = 1'b0;
      for (int p = 0; p < NPORT; p++) begin
        w = '0;
        if (stim_q[p].size() > 0) begin
          w    = stim_q[p].pop_front();
          busy = 1'b1;
        end
        gmii_rx_dv[p] = w[8];
        gmii_rxd[p]   = w[7:0];
      end
    end
  endtask

  task automatic drain_and_report(input string name);
    int waited;
    int errs;
    waited = 0;
    while (done_cnt != queued_cnt && waited < DRAIN_LIMIT) begin
      @(posedge sys_clk);
      waited++;
    end
    if (done_cnt != queued_cnt) begin
      err_main++;
      $display("%0d expected frames never left the switch", queued_cnt - done_cnt);
    end
    // Quiet window catches frames that should have been dropped
    repeat (SETTLE_CYCLES) @(posedge sys_clk);
    errs = err_main + err_mon - errs_before;
    errs_before = err_main + err_mon;
    n_tests++;
    if (errs == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errs);
    end
  endtask

  // --------------------------------------------------
  // Output compare
  // --------------------------------------------------
  task automatic check_frame(input int o);
    int hit;
    int id;
    int k;
    hit = -1;
    for (int s = NPORT - 1; s >= 0; s--) begin
      if (exp_q[o][s].size() > 0) begin
        if (first_diff(exp_q[o][s][0], o) < 0) begin
          hit = s;
        end
      end
    end
    if (hit >= 0) begin
      id = exp_q[o][hit].pop_front();
      done_cnt++;
    end else begin
      for (int s = NPORT - 1; s >= 0; s--) begin
        if (exp_q[o][s].size() > 0) begin
          hit = s;
        end
      end
      err_mon++;
      if (hit < 0) begin
        $display("Unexpected %0d-byte frame on gmii_tx_en[%0d] at %t", got_len[o], o, $time);
      end else begin
        id = exp_q[o][hit].pop_front();
        done_cnt++;
        k = first_diff(id, o);
        if (k < got_len[o] && k < frame_len[id]) begin
          $display("Error at %t: gmii_txd[%0d] byte %0d got %02h expected %02h",
                   $time, o, k, got_buf[o][k], frame_mem[id][k]);
        end else begin
          $display("Error at %t: gmii_tx_en[%0d] frame length got %0d expected %0d",
                   $time, o, got_len[o], frame_len[id]);
        end
      end
    end
  endtask

  always @(negedge sys_clk) begin
    if (!rst_n) begin
      for (int o = 0; o < NPORT; o++) begin
        got_len[o]  = 0;
        idle_cnt[o] = 0;
        in_frame[o] = 1'b0;
        seen[o]     = 1'b0;
      end
    end else begin
      for (int o = 0; o < NPORT; o++) begin
        if (gmii_tx_en[o]) begin
          if (!in_frame[o]) begin
            if (seen[o] && idle_cnt[o] < IFG_CYCLES) begin
              err_mon++;
              $display("Error at %t: gmii_tx_en[%0d] idle gap got %0d expected %0d or more",
                       $time, o, idle_cnt[o], IFG_CYCLES);
            end
            in_frame[o] = 1'b1;
            got_len[o]  = 0;
          end
          if (got_len[o] < MAX_FRAME_BYTES) begin
            got_buf[o][got_len[o]] = gmii_txd[o];
          end
          got_len[o]++;
        end else if (in_frame[o]) begin
          check_frame(o);
          in_frame[o] = 1'b0;
          seen[o]     = 1'b1;
          idle_cnt[o] = 1;
        end else begin
          idle_cnt[o]++;
        end
      end
    end
  end

  initial begin
    #(WD_CYCLES * 8);
    $display("Watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    $timeformat(-9, 0, " ns", 0);
    seed        = 11;
    n_frames    = 0;
    queued_cnt  = 0;
    done_cnt    = 0;
    err_main    = 0;
    err_mon     = 0;
    errs_before = 0;
    n_tests     = 0;
    rst_n       = 1'b0;
    gmii_rx_dv  = '0;
    gmii_rxd    = '0;
    tbl_wr_en   = 1'b0;
    tbl_wr_idx  = '0;
    tbl_wr_mac  = '0;
    tbl_wr_port = '0;
    for (int e = 0; e < FLOW_ENTRIES; e++) begin
      model_valid[e] = 1'b0;
      model_mac[e]   = {40'h02_11_22_33_44, 8'(e)};
      model_port[e]  = '0;
    end
    repeat (5) @(negedge sys_clk);
    rst_n = 1'b1;

    for (int p = 0; p < NPORT; p++) begin
      queue_frame(p, model_mac[p], 20, 12);
    end
    play_stimulus();
    drain_and_report("Test 1 empty table drops");

    write_entry(0, model_mac[0], 2);
    write_entry(1, model_mac[1], 1);
    write_entry(2, model_mac[2], 3);
    write_entry(3, model_mac[3], 0);
    // Port 1 to MAC 1 is the hairpin
    queue_frame(0, model_mac[0], 20, 12);
    queue_frame(1, model_mac[1], 6, 12);
    queue_frame(2, model_mac[2], 33, 12);
    queue_frame(3, model_mac[3], MAX_FRAME_BYTES, 12);
    play_stimulus();
    drain_and_report("Test 2 known MACs and hairpin");

    queue_frame(0, 48'h0a_bb_cc_dd_ee_01, 30, 12);
    queue_frame(0, model_mac[0], 4, 12);
    queue_frame(0, model_mac[0], 15, 12);
    queue_frame(3, model_mac[1], 1, 3);
    queue_frame(3, model_mac[1], 25, 12);
    play_stimulus();
    drain_and_report("Test 3 unknown MAC and short frame");

    for (int p = 0; p < NPORT; p++) begin
      queue_frame(p, model_mac[2], 40 + 8 * p, 12);
    end
    play_stimulus();
    drain_and_report("Test 4 four inputs to one output");

    write_entry(2, model_mac[2], 1);
    queue_frame(0, model_mac[2], 18, 12);
    queue_frame(3, model_mac[2], 27, 12);
    play_stimulus();
    drain_and_report("Test 5 entry rewrite");

    // One MAC per output keeps the load even
    write_entry(2, model_mac[2], 3);
    for (int p = 0; p < NPORT; p++) begin
      for (int n = 0; n < 40; n++) begin
        mac = model_mac[$unsigned($random(seed)) % FLOW_ENTRIES];
        len = MAC_BYTES + $unsigned($random(seed)) % (MAX_FRAME_BYTES - MAC_BYTES + 1);
        queue_frame(p, mac, len, 32 + $unsigned($random(seed)) % 16);
      end
    end
    play_stimulus();
    drain_and_report("Test 6 random traffic");

    $display("Summary: %0d tests, %0d frames checked, %0d errors",
             n_tests, done_cnt, err_main + err_mon);
    if (err_main + err_mon == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
rtl/switch_pkg.sv
rtl/byte_fifo.sv
rtl/gmii_rx_gate.sv
rtl/flow_table.sv
rtl/forwarder.sv
rtl/tx_mixer.sv
rtl/switch_top.sv
verif/tb_switch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the switch testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_switch -o tb_switch
sim_out=$(./obj_dir/tb_switch)
echo "$sim_out"

if ! echo "$sim_out" | grep -q "TESTS PASSED"; then
  exit 1
fi
